/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = learn_costs_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	$(SIM) | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/learn_costs_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module learn_costs_fsm (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	input  route_pkg::fwd_pkt_t pkt,
	input  route_pkg::word_t    rd_word,
	input  logic                n_end,
	input  logic                k_end,
	input  logic                full,
	output route_pkg::region_t  region,
	output route_pkg::wsel_t    wsel,
	output logic                mem_we,
	output logic                load_nbr_count,
	output logic                load_sink_count,
	output logic                clr_n,
	output logic                inc_n,
	output logic                clr_k,
	output logic                inc_k,
	output route_pkg::fwd_pkt_t pkt_q,
	output route_pkg::word_t    rd_hold,
	output logic                done,
	output logic                reinit
);

	typedef enum logic [3:0] {
		st_idle,
		st_rd_nbr_count,
		st_rd_sink_count,
		st_scan,          // end check on n
		st_scan_rd,       // compare neighbor id n
		st_wr_id,
		st_wr_batt,
		st_rd_q,
		st_wr_q,
		st_wr_cluster,
		st_copy_chk,
		st_copy_rd,
		st_copy_wr,
		st_wr_sink_count,
		st_wr_nbr_count
	} state_t;

	state_t state;
	logic busy;
	logic accept;
	logic match;
	logic append;  // source not in table, new entry at n
	logic q_lower; // stored q below incoming, shown as reinit at the end

	assign busy = (state != st_idle);
	assign accept = start && !busy;
	assign match = (rd_word == pkt_q.source_id);

	// counter strobes, one cycle each
	assign load_nbr_count = (state == st_rd_nbr_count);
	assign clr_n = (state == st_rd_nbr_count);
	assign load_sink_count = (state == st_rd_sink_count);
	assign clr_k = (state == st_rd_sink_count);
	assign inc_n = (state == st_scan_rd) && !match;
	assign inc_k = (state == st_copy_wr);

	always_ff @(posedge clock) begin
		if (accept)
			pkt_q <= pkt;
		rd_hold <= rd_word; // known sink word for the following copy write
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= st_idle;
			region <= route_pkg::rg_nbr_count;
			wsel <= route_pkg::ws_rd_word;
			mem_we <= 1'b0;
			append <= 1'b0;
			q_lower <= 1'b0;
			done <= 1'b0;
			reinit <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						done <= 1'b0;
						reinit <= 1'b0;
						append <= 1'b0;
						q_lower <= 1'b0;
						region <= route_pkg::rg_nbr_count;
						state <= st_rd_nbr_count;
					end
				end
				st_rd_nbr_count: begin
					region <= route_pkg::rg_known_sink_count;
					state <= st_rd_sink_count;
				end
				st_rd_sink_count: state <= st_scan;
				st_scan: begin
					region <= route_pkg::rg_nbr_id;
					if (!n_end) begin
						state <= st_scan_rd;
					end else if (full) begin
						done <= 1'b1; // no room, table untouched
						state <= st_idle;
					end else begin
						append <= 1'b1;
						wsel <= route_pkg::ws_source_id;
						mem_we <= 1'b1;
						state <= st_wr_id;
					end
				end
				st_scan_rd: begin
					if (match) begin
						region <= route_pkg::rg_battery;
						wsel <= route_pkg::ws_battery;
						mem_we <= 1'b1;
						state <= st_wr_batt;
					end else begin
						state <= st_scan;
					end
				end
				st_wr_id: begin
					region <= route_pkg::rg_battery;
					wsel <= route_pkg::ws_battery;
					state <= st_wr_batt;
				end
				st_wr_batt: begin
					region <= route_pkg::rg_qvalue;
					wsel <= route_pkg::ws_qvalue;
					if (append) begin
						state <= st_wr_q;
					end else begin
						mem_we <= 1'b0; // old q value is read first
						state <= st_rd_q;
					end
				end
				st_rd_q: begin
					q_lower <= (rd_word < pkt_q.q_value);
					mem_we <= 1'b1;
					state <= st_wr_q;
				end
				st_wr_q: begin
					if (append) begin
						region <= route_pkg::rg_cluster;
						wsel <= route_pkg::ws_cluster;
						state <= st_wr_cluster;
					end else begin
						mem_we <= 1'b0;
						state <= st_copy_chk;
					end
				end
				st_wr_cluster: begin
					mem_we <= 1'b0;
					state <= st_copy_chk;
				end
				st_copy_chk: begin
					if (k_end) begin
						region <= route_pkg::rg_nbr_sink_count;
						wsel <= route_pkg::ws_sink_k;
						mem_we <= 1'b1;
						state <= st_wr_sink_count;
					end else begin
						region <= route_pkg::rg_known_sink;
						state <= st_copy_rd;
					end
				end
				st_copy_rd: begin
					region <= route_pkg::rg_sink_id;
					wsel <= route_pkg::ws_rd_word;
					mem_we <= 1'b1;
					state <= st_copy_wr;
				end
				st_copy_wr: begin
					mem_we <= 1'b0;
					state <= st_copy_chk;
				end
				st_wr_sink_count: begin
					if (append) begin
						region <= route_pkg::rg_nbr_count;
						wsel <= route_pkg::ws_nbr_count_inc;
						state <= st_wr_nbr_count;
					end else begin
						mem_we <= 1'b0;
						done <= 1'b1;
						reinit <= q_lower;
						state <= st_idle;
					end
				end
				st_wr_nbr_count: begin
					mem_we <= 1'b0;
					done <= 1'b1; // new entry, reinit stays low
					state <= st_idle;
				end
				default: begin
					mem_we <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/learn_costs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module learn_costs_top #(
	parameter int MEM_BYTES = 2048
) (
	input  logic                clock,
	input  logic                nrst,
	input  logic                start,
	input  route_pkg::fwd_pkt_t pkt,
	input  logic                host_we,
	input  route_pkg::word_t    host_addr,
	input  route_pkg::word_t    host_wdata,
	output route_pkg::word_t    host_rdata,
	output logic                done,
	output logic                reinit
);

	route_pkg::region_t region;
	route_pkg::wsel_t wsel;
	logic mem_we;
	logic load_nbr_count;
	logic load_sink_count;
	logic clr_n;
	logic inc_n;
	logic clr_k;
	logic inc_k;
	logic n_end;
	logic k_end;
	logic full;
	route_pkg::fwd_pkt_t pkt_q;
	route_pkg::word_t rd_word;  // engine port read data
	route_pkg::word_t rd_hold;
	route_pkg::word_t n;
	route_pkg::word_t k;
	route_pkg::word_t nbr_count_inc;
	route_pkg::word_t addr;
	route_pkg::word_t wdata;

	learn_costs_fsm u_fsm (
		.clock           (clock),
		.nrst            (nrst),
		.start           (start),
		.pkt             (pkt),
		.rd_word         (rd_word),
		.n_end           (n_end),
		.k_end           (k_end),
		.full            (full),
		.region          (region),
		.wsel            (wsel),
		.mem_we          (mem_we),
		.load_nbr_count  (load_nbr_count),
		.load_sink_count (load_sink_count),
		.clr_n           (clr_n),
		.inc_n           (inc_n),
		.clr_k           (clr_k),
		.inc_k           (inc_k),
		.pkt_q           (pkt_q),
		.rd_hold         (rd_hold),
		.done            (done),
		.reinit          (reinit)
	);

	scan_counters u_counters (
		.clock           (clock),
		.nrst            (nrst),
		.rd_word         (rd_word),
		.load_nbr_count  (load_nbr_count),
		.load_sink_count (load_sink_count),
		.clr_n           (clr_n),
		.inc_n           (inc_n),
		.clr_k           (clr_k),
		.inc_k           (inc_k),
		.n               (n),
		.k               (k),
		.nbr_count_inc   (nbr_count_inc),
		.n_end           (n_end),
		.k_end           (k_end),
		.full            (full)
	);

	// copy writes take the word read one cycle earlier
	table_access u_access (
		.region        (region),
		.wsel          (wsel),
		.n             (n),
		.k             (k),
		.nbr_count_inc (nbr_count_inc),
		.pkt_q         (pkt_q),
		.rd_word       (rd_hold),
		.addr          (addr),
		.wdata         (wdata)
	);

	route_table_ram #(
		.MEM_BYTES (MEM_BYTES)
	) u_ram (
		.clock   (clock),
		.a_we    (mem_we),
		.a_addr  (addr),
		.a_wdata (wdata),
		.a_rdata (rd_word),
		.b_we    (host_we),
		.b_addr  (host_addr),
		.b_wdata (host_wdata),
		.b_rdata (host_rdata)
	);

endmodule

`default_nettype wire

/* hdl/route_pkg.sv */
`default_nettype none

package route_pkg;

	// one table word, byte addressed at even addresses
	typedef logic [15:0] word_t;

	// forwarding packet as handed over by the parser
	typedef struct packed {
		word_t source_id;
		word_t battery_stat;
		word_t q_value;
		word_t cluster_id;
	} fwd_pkt_t;

	// routing table layout, byte addresses
	parameter word_t KNOWN_SINKS_BASE      = 16'h008;
	parameter word_t NBR_ID_BASE           = 16'h048;
	parameter word_t CLUSTER_BASE          = 16'h0C8;
	parameter word_t BATTERY_BASE          = 16'h148;
	parameter word_t QVALUE_BASE           = 16'h1C8;
	parameter word_t SINK_IDS_BASE         = 16'h248; // 16 bytes per neighbor
	parameter word_t KNOWN_SINK_COUNT_ADDR = 16'h688;
	parameter word_t NBR_COUNT_ADDR        = 16'h68A;
	parameter word_t NBR_SINK_COUNT_BASE   = 16'h68E;

	// table capacity
	parameter word_t MAX_NEIGHBORS = 16'd64;
	parameter word_t MAX_SINKS     = 16'd8; // one sink slot holds 8 ids

	// which table location the engine addresses
	typedef enum logic [3:0] {
		rg_nbr_count,
		rg_known_sink_count,
		rg_known_sink,     // indexed by k
		rg_nbr_id,         // by n
		rg_battery,
		rg_qvalue,
		rg_cluster,
		rg_sink_id,        // by n and k
		rg_nbr_sink_count
	} region_t;

	// source of the word written to the table
	typedef enum logic [2:0] {
		ws_battery,
		ws_qvalue,
		ws_source_id,
		ws_cluster,
		ws_rd_word,        // word read in the previous cycle
		ws_sink_k,
		ws_nbr_count_inc
	} wsel_t;

endpackage

`default_nettype wire

/* hdl/route_table_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module route_table_ram #(
	parameter int MEM_BYTES = 2048
) (
	input  logic             clock,
	input  logic             a_we,
	input  route_pkg::word_t a_addr,
	input  route_pkg::word_t a_wdata,
	output route_pkg::word_t a_rdata,
	input  logic             b_we,
	input  route_pkg::word_t b_addr,
	input  route_pkg::word_t b_wdata,
	output route_pkg::word_t b_rdata
);

	localparam int WORDS = MEM_BYTES / 2;
	localparam int AW = $clog2(WORDS);

	route_pkg::word_t mem [WORDS];

	// byte address bit 0 is dropped, words sit at even addresses
	always_ff @(posedge clock) begin
		if (b_we)
			mem[b_addr[AW:1]] <= b_wdata;
		if (a_we)
			mem[a_addr[AW:1]] <= a_wdata; // engine port wins on the same word
	end

	assign a_rdata = mem[a_addr[AW:1]];
	assign b_rdata = mem[b_addr[AW:1]];

endmodule

`default_nettype wire

/* hdl/scan_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_counters (
	input  logic             clock,
	input  logic             nrst,
	input  route_pkg::word_t rd_word,
	input  logic             load_nbr_count,
	input  logic             load_sink_count,
	input  logic             clr_n,
	input  logic             inc_n,
	input  logic             clr_k,
	input  logic             inc_k,
	output route_pkg::word_t n,
	output route_pkg::word_t k,
	output route_pkg::word_t nbr_count_inc,
	output logic             n_end,
	output logic             k_end,
	output logic             full
);

	route_pkg::word_t nbr_count;
	route_pkg::word_t sink_count;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			n <= '0;
			k <= '0;
			nbr_count <= '0;
			sink_count <= '0;
		end else begin
			if (load_nbr_count)
				nbr_count <= rd_word;
			// a longer known-sink list would overrun the per-neighbor slot
			if (load_sink_count)
				sink_count <= (rd_word > route_pkg::MAX_SINKS) ? route_pkg::MAX_SINKS : rd_word;
			if (clr_n)
				n <= '0;
			else if (inc_n)
				n <= n + 16'd1;
			if (clr_k)
				k <= '0;
			else if (inc_k)
				k <= k + 16'd1;
		end
	end

	assign n_end = (n == nbr_count);
	assign k_end = (k == sink_count);
	assign full = (nbr_count >= route_pkg::MAX_NEIGHBORS);
	assign nbr_count_inc = nbr_count + 16'd1;

endmodule

`default_nettype wire

/* hdl/table_access.sv */
`timescale 1ns/1ps
`default_nettype none

module table_access (
	input  route_pkg::region_t  region,
	input  route_pkg::wsel_t    wsel,
	input  route_pkg::word_t    n,
	input  route_pkg::word_t    k,
	input  route_pkg::word_t    nbr_count_inc,
	input  route_pkg::fwd_pkt_t pkt_q,
	input  route_pkg::word_t    rd_word,
	output route_pkg::word_t    addr,
	output route_pkg::word_t    wdata
);

	route_pkg::word_t n2;   // word offset of neighbor n
	route_pkg::word_t k2;
	route_pkg::word_t slot; // start of neighbor n's sink slot

	assign n2 = {n[14:0], 1'b0};
	assign k2 = {k[14:0], 1'b0};
	assign slot = route_pkg::SINK_IDS_BASE + {n[11:0], 4'b0000};

	always_comb begin
		case (region)
			route_pkg::rg_nbr_count:        addr = route_pkg::NBR_COUNT_ADDR;
			route_pkg::rg_known_sink_count: addr = route_pkg::KNOWN_SINK_COUNT_ADDR;
			route_pkg::rg_known_sink:       addr = route_pkg::KNOWN_SINKS_BASE + k2;
			route_pkg::rg_nbr_id:           addr = route_pkg::NBR_ID_BASE + n2;
			route_pkg::rg_battery:          addr = route_pkg::BATTERY_BASE + n2;
			route_pkg::rg_qvalue:           addr = route_pkg::QVALUE_BASE + n2;
			route_pkg::rg_cluster:          addr = route_pkg::CLUSTER_BASE + n2;
			route_pkg::rg_sink_id:          addr = slot + k2;
			route_pkg::rg_nbr_sink_count:   addr = route_pkg::NBR_SINK_COUNT_BASE + n2;
			default:                        addr = route_pkg::NBR_COUNT_ADDR;
		endcase
	end

	always_comb begin
		case (wsel)
			route_pkg::ws_battery:       wdata = pkt_q.battery_stat;
			route_pkg::ws_qvalue:        wdata = pkt_q.q_value;
			route_pkg::ws_source_id:     wdata = pkt_q.source_id;
			route_pkg::ws_cluster:       wdata = pkt_q.cluster_id;
			route_pkg::ws_rd_word:       wdata = rd_word;
			route_pkg::ws_sink_k:        wdata = k; // k has reached the sink count here
			route_pkg::ws_nbr_count_inc: wdata = nbr_count_inc;
			default:                     wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* list.f */
hdl/route_pkg.sv
hdl/route_table_ram.sv
hdl/scan_counters.sv
hdl/table_access.sv
hdl/learn_costs_fsm.sv
hdl/learn_costs_top.sv
tests/learn_costs_sva.sv
tests/learn_costs_tb.sv

/* tests/learn_costs_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module learn_costs_sva (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic busy,
	input logic mem_we,
	input logic done,
	input logic reinit
);

	int unsigned fail_count = 0; // read by the testbench at the end

	// engine port stays quiet outside a packet
	idle_no_write: assert property (@(posedge clock) disable iff (!nrst) !busy |-> !mem_we)
		else begin
			$error("engine wrote the table while idle");
			fail_count++;
		end

	start_clears_done: assert property (@(posedge clock) disable iff (!nrst)
		(start && !busy) |=> !done)
		else begin
			$error("done high right after an accepted start");
			fail_count++;
		end

	// reinit only moves with a new packet or with the end of one
	reinit_stable: assert property (@(posedge clock) disable iff (!nrst)
		$changed(reinit) |-> ($past(start && !busy) || $rose(done)))
		else begin
			$error("reinit changed outside start or done");
			fail_count++;
		end

endmodule

bind learn_costs_fsm learn_costs_sva u_sva (
	.clock  (clock),
	.nrst   (nrst),
	.start  (start),
	.busy   (busy),
	.mem_we (mem_we),
	.done   (done),
	.reinit (reinit)
);

`default_nettype wire

/* tests/learn_costs_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module learn_costs_tb;

	// scan of a full table plus a full sink copy, with some margin
	localparam int WORST_CYCLES = 8 + 2 * int'(route_pkg::MAX_NEIGHBORS)
		+ 3 * int'(route_pkg::MAX_SINKS);
	localparam int TABLE_WORDS = 1024;
	localparam int RAND_PACKETS = 20;
	localparam int NUM_PACKETS = 6 + RAND_PACKETS;
	// every packet also pays for a preload and a full readback
	localparam int WATCHDOG_CYCLES = (NUM_PACKETS + 2) * (WORST_CYCLES + 3 * TABLE_WORDS);

	logic clock;
	logic nrst;
	logic start;
	route_pkg::fwd_pkt_t pkt;
	logic host_we;
	route_pkg::word_t host_addr;
	route_pkg::word_t host_wdata;
	route_pkg::word_t host_rdata;
	logic done;
	logic reinit;

	route_pkg::word_t model [0:TABLE_WORDS-1]; // reference copy of the table
	int seed;
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;

	learn_costs_top #(
		.MEM_BYTES (2048)
	) dut (
		.clock      (clock),
		.nrst       (nrst),
		.start      (start),
		.pkt        (pkt),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.done       (done),
		.reinit     (reinit)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic logic [9:0] widx(input route_pkg::word_t a);
		return a[10:1];
	endfunction

	function automatic route_pkg::word_t entry_addr(input route_pkg::word_t base,
			input route_pkg::word_t i);
		return base + i * 16'd2;
	endfunction

	function automatic route_pkg::word_t slot_addr(input route_pkg::word_t n,
			input route_pkg::word_t k);
		return route_pkg::SINK_IDS_BASE + n * 16'd16 + k * 16'd2;
	endfunction

	function automatic route_pkg::fwd_pkt_t pkt_of(input route_pkg::word_t src,
			input route_pkg::word_t batt, input route_pkg::word_t q, input route_pkg::word_t cl);
		route_pkg::fwd_pkt_t p;
		p.source_id = src;
		p.battery_stat = batt;
		p.q_value = q;
		p.cluster_id = cl;
		return p;
	endfunction

	task automatic check_value(input string name, input route_pkg::word_t got,
			input route_pkg::word_t exp);
		assert (got == exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// write lands on the next edge, we is dropped by the next read or start
	task automatic set_word(input route_pkg::word_t a, input route_pkg::word_t d);
		@(posedge clock);
		host_we <= 1'b1;
		host_addr <= a;
		host_wdata <= d;
		model[widx(a)] = d;
	endtask

	task automatic read_word(input route_pkg::word_t a, output route_pkg::word_t d);
		@(posedge clock);
		host_we <= 1'b0;
		host_addr <= a;
		@(negedge clock);
		d = host_rdata;
	endtask

	task automatic check_table();
		route_pkg::word_t got;
		for (route_pkg::word_t a = 16'd0; a < 16'd2048; a += 16'd2) begin
			read_word(a, got);
			check_value($sformatf("host_rdata @%h", a), got, model[widx(a)]);
		end
	endtask

	task automatic fill_table();
		for (route_pkg::word_t a = 16'd0; a < 16'd2048; a += 16'd2)
			set_word(a, (a * 16'h9e37) ^ {a[4:0], a[15:5]});
	endtask

	task automatic set_neighbors(input route_pkg::word_t cnt, input route_pkg::word_t first_id);
		for (route_pkg::word_t i = 16'd0; i < cnt; i++)
			set_word(entry_addr(route_pkg::NBR_ID_BASE, i), first_id + i);
		set_word(route_pkg::NBR_COUNT_ADDR, cnt);
	endtask

	task automatic set_sinks(input route_pkg::word_t cnt);
		for (route_pkg::word_t k = 16'd0; k < cnt; k++)
			set_word(entry_addr(route_pkg::KNOWN_SINKS_BASE, k), 16'h0a00 ^ 16'($random(seed)));
		set_word(route_pkg::KNOWN_SINK_COUNT_ADDR, cnt);
	endtask

	// what one packet does to the table
	task automatic model_apply(input route_pkg::fwd_pkt_t p, output logic exp_reinit);
		route_pkg::word_t cnt;
		route_pkg::word_t sinks;
		route_pkg::word_t idx;
		logic found;
		cnt = model[widx(route_pkg::NBR_COUNT_ADDR)];
		sinks = model[widx(route_pkg::KNOWN_SINK_COUNT_ADDR)];
		if (sinks > route_pkg::MAX_SINKS)
			sinks = route_pkg::MAX_SINKS;
		found = 1'b0;
		idx = cnt;
		for (route_pkg::word_t i = 16'd0; i < cnt; i++) begin
			if (!found && model[widx(entry_addr(route_pkg::NBR_ID_BASE, i))] == p.source_id) begin
				found = 1'b1;
				idx = i;
			end
		end
		exp_reinit = 1'b0;
		if (found) begin
			exp_reinit = model[widx(entry_addr(route_pkg::QVALUE_BASE, idx))] < p.q_value;
		end else if (cnt >= route_pkg::MAX_NEIGHBORS) begin
			return; // no room
		end else begin
			model[widx(entry_addr(route_pkg::NBR_ID_BASE, idx))] = p.source_id;
			model[widx(entry_addr(route_pkg::CLUSTER_BASE, idx))] = p.cluster_id;
			model[widx(route_pkg::NBR_COUNT_ADDR)] = cnt + 16'd1;
		end
		model[widx(entry_addr(route_pkg::BATTERY_BASE, idx))] = p.battery_stat;
		model[widx(entry_addr(route_pkg::QVALUE_BASE, idx))] = p.q_value;
		for (route_pkg::word_t k = 16'd0; k < sinks; k++)
			model[widx(slot_addr(idx, k))] =
				model[widx(entry_addr(route_pkg::KNOWN_SINKS_BASE, k))];
		model[widx(entry_addr(route_pkg::NBR_SINK_COUNT_BASE, idx))] = sinks;
	endtask

	task automatic run_packet(input route_pkg::fwd_pkt_t p);
		logic exp_reinit;
		int cycles;
		model_apply(p, exp_reinit);
		@(posedge clock);
		host_we <= 1'b0;
		pkt <= p;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!done && cycles < 2 * WORST_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		assert (done) else begin
			$display("engine did not raise done within %0d cycles", 2 * WORST_CYCLES);
			errors++;
		end
		check_value("reinit", 16'(reinit), 16'(exp_reinit));
		check_table();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	task automatic test_reset();
		route_pkg::word_t got;
		errors_at_start = errors;
		@(negedge clock);
		check_value("done", 16'(done), 16'd0);
		check_value("reinit", 16'(reinit), 16'd0);
		set_word(16'h07fe, 16'ha5c3);
		read_word(16'h07fe, got);
		check_value("host_rdata", got, 16'ha5c3);
		end_test("reset");
	endtask

	task automatic test_append();
		route_pkg::word_t got;
		errors_at_start = errors;
		set_neighbors(16'd3, 16'h0101);
		set_sinks(16'd3);
		run_packet(pkt_of(16'h0200, 16'h0055, 16'h0300, 16'h0007));
		read_word(route_pkg::NBR_COUNT_ADDR, got);
		check_value("nbr_count", got, 16'd4);
		end_test("append");
	endtask

	// neighbor 2 of 5 is the source
	task automatic test_update(input string name, input route_pkg::word_t q_stored,
			input route_pkg::word_t q_pkt);
		errors_at_start = errors;
		set_neighbors(16'd5, 16'h0301);
		set_word(entry_addr(route_pkg::QVALUE_BASE, 16'd2), q_stored);
		set_sinks(16'd5);
		run_packet(pkt_of(16'h0303, 16'h0066, q_pkt, 16'h0009));
		end_test(name);
	endtask

	task automatic test_full();
		errors_at_start = errors;
		set_neighbors(route_pkg::MAX_NEIGHBORS, 16'h1000);
		set_sinks(16'd4);
		run_packet(pkt_of(16'h0fff, 16'h0011, 16'h0022, 16'h0033));
		end_test("full table");
	endtask

	task automatic test_random();
		route_pkg::word_t cnt;
		errors_at_start = errors;
		cnt = 16'd4 + 16'($random(seed) & 7);
		for (route_pkg::word_t i = 16'd0; i < cnt; i++) begin
			set_word(entry_addr(route_pkg::NBR_ID_BASE, i), 16'h0040 + 16'($random(seed) & 15));
			set_word(entry_addr(route_pkg::QVALUE_BASE, i), 16'($random(seed)));
		end
		set_word(route_pkg::NBR_COUNT_ADDR, cnt);
		repeat (RAND_PACKETS) begin
			set_sinks(16'($random(seed)) % 16'd12); // some lists longer than a sink slot
			run_packet(pkt_of(16'h0040 + 16'($random(seed) & 15), 16'($random(seed)),
				16'($random(seed)), 16'($random(seed))));
		end
		end_test("random sequence");
	endtask

	initial begin
		seed = 32'h9598694f;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		nrst = 1'b0;
		start = 1'b0;
		pkt = '0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		repeat (8) @(posedge clock);
		nrst <= 1'b1;
		test_reset();
		fill_table();
		test_append();
		test_update("update with reinit", 16'h0100, 16'h0180);
		test_update("update without reinit", 16'h0200, 16'h0180);
		test_update("update equal q", 16'h0180, 16'h0180);
		test_full();
		test_random();
		errors += int'(dut.u_fsm.u_sva.fail_count);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
